// ==== Makefile ====
SRCS := $(shell cat list.f)

.PHONY: run clean

run: obj_dir/Vtb_core_controller
	@out="$$(./obj_dir/Vtb_core_controller)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

obj_dir/Vtb_core_controller: list.f $(SRCS)
	verilator --binary --assert -j 0 --top-module tb_core_controller -f list.f

clean:
	rm -rf obj_dir

// ==== controller_props.sv ====
//////////////////////////////////////////////////
// concurrent checks on the core controller
// exception redirect, idle fetch, branch spacing
//////////////////////////////////////////////////

module controller_props import ctrl_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input logic    exc_ack_i,
  input logic    pc_set_i,
  input pc_mux_t pc_mux_i,
  input logic    ctrl_busy_i,
  input logic    instr_req_i,
  input logic    branch_taken_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // an acknowledged exception always redirects fetch to the handler
  ack_sets_exception_pc: assert property (@(posedge clk) disable iff (!rst_n)
    exc_ack_i |-> (pc_set_i && (pc_mux_i == PC_EXCEPTION)))
    else $error("exception acknowledged without a redirect to the exception PC");

  // no fetch request while idle
  idle_means_no_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    !ctrl_busy_i |-> !instr_req_i)
    else $error("instruction request raised while the controller is idle");

  // the branch in EX flushes ID, so a second one cannot follow directly
  branch_not_back_to_back: assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_i |=> !branch_taken_i)
    else $error("taken branch reported on two cycles in a row");

endmodule

bind core_controller controller_props i_controller_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .exc_ack_i      (exc_ack_o),
  .pc_set_i       (pc_set_o),
  .pc_mux_i       (pc_mux_o),
  .ctrl_busy_i    (ctrl_busy_o),
  .instr_req_i    (instr_req_o),
  .branch_taken_i (branch_taken_ex_i)
);

// ==== core_controller.sv ====
//////////////////////////////////////////////////
// core controller top level
// control FSM plus operand hazard unit
//////////////////////////////////////////////////

module core_controller import ctrl_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // decode and pipeline status
  input  logic                  fetch_enable_i,
  input  logic                  instr_valid_i,
  input  logic                  pipe_flush_i,
  input  logic                  eret_insn_i,
  input  logic                  illegal_insn_i,
  input  jump_kind_t            jump_in_dec_i,
  input  logic                  branch_taken_ex_i,
  input  logic                  exc_req_i,
  input  logic                  ext_req_i,
  input  logic                  id_ready_i,
  input  logic                  ex_valid_i,

  // register addresses and write enables
  input  logic [REG_ADDR_W-1:0] rs_a_addr_i,
  input  logic [REG_ADDR_W-1:0] rs_b_addr_i,
  input  logic [REG_ADDR_W-1:0] waddr_ex_i,
  input  logic [REG_ADDR_W-1:0] waddr_wb_i,
  input  logic                  rega_used_i,
  input  logic                  regb_used_i,
  input  logic                  we_ex_i,
  input  logic                  alu_we_ex_i,
  input  logic                  we_wb_i,
  input  logic                  data_req_ex_i,

  // fetch and exception control
  output logic                  instr_req_o,
  output logic                  ctrl_busy_o,
  output logic                  is_decoding_o,
  output logic                  pc_set_o,
  output pc_mux_t               pc_mux_o,
  output logic                  exc_ack_o,
  output logic                  exc_save_if_o,
  output logic                  exc_save_id_o,
  output logic                  exc_save_takenbranch_o,
  output logic                  exc_restore_id_o,
  output logic                  halt_if_o,
  output logic                  halt_id_o,

  // hazard results
  output fw_sel_t               operand_a_fw_sel_o,
  output fw_sel_t               operand_b_fw_sel_o,
  output logic                  load_stall_o,
  output logic                  jr_stall_o,
  output logic                  deassert_we_o
);

  // FSM and hazard unit feed each other
  logic is_decoding;
  logic jr_stall;

  assign is_decoding_o = is_decoding;
  assign jr_stall_o    = jr_stall;

  ctrl_fsm i_ctrl_fsm (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .fetch_enable_i         (fetch_enable_i),
    .instr_valid_i          (instr_valid_i),
    .pipe_flush_i           (pipe_flush_i),
    .eret_insn_i            (eret_insn_i),
    .jump_in_dec_i          (jump_in_dec_i),
    .branch_taken_ex_i      (branch_taken_ex_i),
    .exc_req_i              (exc_req_i),
    .ext_req_i              (ext_req_i),
    .id_ready_i             (id_ready_i),
    .ex_valid_i             (ex_valid_i),
    .jr_stall_i             (jr_stall),
    .instr_req_o            (instr_req_o),
    .ctrl_busy_o            (ctrl_busy_o),
    .is_decoding_o          (is_decoding),
    .pc_set_o               (pc_set_o),
    .pc_mux_o               (pc_mux_o),
    .exc_ack_o              (exc_ack_o),
    .exc_save_if_o          (exc_save_if_o),
    .exc_save_id_o          (exc_save_id_o),
    .exc_save_takenbranch_o (exc_save_takenbranch_o),
    .exc_restore_id_o       (exc_restore_id_o),
    .halt_if_o              (halt_if_o),
    .halt_id_o              (halt_id_o)
  );

  operand_hazard_unit i_operand_hazard_unit (
    .is_decoding_i      (is_decoding),
    .illegal_insn_i     (illegal_insn_i),
    .jump_in_dec_i      (jump_in_dec_i),
    .rs_a_addr_i        (rs_a_addr_i),
    .rs_b_addr_i        (rs_b_addr_i),
    .waddr_ex_i         (waddr_ex_i),
    .waddr_wb_i         (waddr_wb_i),
    .rega_used_i        (rega_used_i),
    .regb_used_i        (regb_used_i),
    .we_ex_i            (we_ex_i),
    .alu_we_ex_i        (alu_we_ex_i),
    .we_wb_i            (we_wb_i),
    .data_req_ex_i      (data_req_ex_i),
    .operand_a_fw_sel_o (operand_a_fw_sel_o),
    .operand_b_fw_sel_o (operand_b_fw_sel_o),
    .load_stall_o       (load_stall_o),
    .jr_stall_o         (jr_stall),
    .deassert_we_o      (deassert_we_o)
  );

endmodule

// ==== ctrl_fsm.sv ====
//////////////////////////////////////////////////
// main control FSM of the core
// boot, sleep and wake, jump and branch issue,
// exception entry and return, WFI pipeline flush
//////////////////////////////////////////////////

module ctrl_fsm import ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  logic       fetch_enable_i,
  input  logic       instr_valid_i,
  input  logic       pipe_flush_i,
  input  logic       eret_insn_i,
  input  jump_kind_t jump_in_dec_i,
  input  logic       branch_taken_ex_i,
  input  logic       exc_req_i,
  input  logic       ext_req_i,
  input  logic       id_ready_i,
  input  logic       ex_valid_i,
  input  logic       jr_stall_i,

  output logic       instr_req_o,
  output logic       ctrl_busy_o,
  output logic       is_decoding_o,
  output logic       pc_set_o,
  output pc_mux_t    pc_mux_o,
  output logic       exc_ack_o,
  output logic       exc_save_if_o,
  output logic       exc_save_id_o,
  output logic       exc_save_takenbranch_o,
  output logic       exc_restore_id_o,
  output logic       halt_if_o,
  output logic       halt_id_o
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  // set once a jump or eret has redirected fetch, held while ID stalls
  logic jump_done;
  logic jump_done_q;
  logic is_jump;

  assign is_jump = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);

  //////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////

  always_comb
  begin
    // defaults: fetching, busy, nothing redirected
    instr_req_o            = 1'b1;
    ctrl_busy_o            = 1'b1;
    is_decoding_o          = 1'b0;
    pc_set_o               = 1'b0;
    pc_mux_o               = PC_BOOT;
    exc_ack_o              = 1'b0;
    exc_save_if_o          = 1'b0;
    exc_save_id_o          = 1'b0;
    exc_save_takenbranch_o = 1'b0;
    exc_restore_id_o       = 1'b0;
    halt_if_o              = 1'b0;
    halt_id_o              = 1'b0;
    jump_done              = jump_done_q;
    state_d                = state_q;

    case (state_q)
      // idle after reset until fetch is enabled
      RESET:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
        begin
          state_d = BOOT_SET;
        end
      end

      // load the boot address into the fetch PC
      BOOT_SET:
      begin
        pc_mux_o = PC_BOOT;
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end

      // pipeline empty, wake on fetch enable or a pending exception
      SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req_i)
        begin
          state_d = FIRST_FETCH;
        end
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH:
      begin
        if (id_ready_i)
        begin
          state_d = DECODE;
        end
        // nothing in ID yet, so the IF PC is the return address
        if (exc_req_i)
        begin
          pc_mux_o      = PC_EXCEPTION;
          pc_set_o      = 1'b1;
          exc_ack_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end
      end

      DECODE:
      begin
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;

          if (is_jump)
          begin
            // target known in ID, redirect once the operand is ready
            pc_mux_o = PC_JUMP;
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o  = 1'b1;
              jump_done = 1'b1;
            end
          end
          else if (exc_req_i)
          begin
            // kill the instruction in ID, it becomes the saved PC
            pc_mux_o      = PC_EXCEPTION;
            pc_set_o      = 1'b1;
            exc_ack_o     = 1'b1;
            exc_save_id_o = 1'b1;
            halt_id_o     = 1'b1;
          end

          // exception return
          if (eret_insn_i)
          begin
            pc_mux_o         = PC_ERET;
            exc_restore_id_o = 1'b1;
            if (!jump_done_q)
            begin
              pc_set_o  = 1'b1;
              jump_done = 1'b1;
            end
          end

          // WFI, or eret back into sleep: drain EX and WB first
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i))
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // interrupt while ID is empty
        if (!instr_valid_i && !branch_taken_ex_i && ext_req_i)
        begin
          pc_mux_o      = PC_EXCEPTION;
          pc_set_o      = 1'b1;
          exc_ack_o     = 1'b1;
          exc_save_if_o = 1'b1;
          halt_id_o     = 1'b1;
        end

        // taken branch in EX discards whatever sits in ID
        if (branch_taken_ex_i)
        begin
          pc_mux_o      = PC_BRANCH;
          pc_set_o      = 1'b1;
          is_decoding_o = 1'b0;
          // interrupt returns to the branch target
          if (ext_req_i)
          begin
            pc_mux_o               = PC_EXCEPTION;
            exc_ack_o              = 1'b1;
            exc_save_takenbranch_o = 1'b1;
            halt_id_o              = 1'b1;
          end
        end
      end

      // NOP into EX until the last instruction leaves it
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
        begin
          state_d = FLUSH_WB;
        end
      end

      // one more cycle for WB, then resume or sleep
      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i)
        begin
          halt_if_o = 1'b0;
          state_d   = DECODE;
        end
        else
        begin
          state_d = SLEEP;
        end
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // state registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // cleared as soon as ID accepts the next instruction
      jump_done_q <= jump_done & ~id_ready_i;
    end
  end

endmodule

// ==== ctrl_pkg.sv ====
//////////////////////////////////////////////////
// shared definitions for the core controller
// register address width, controller states,
// fetch PC source, jump kinds and the operand
// forwarding selects
//////////////////////////////////////////////////

package ctrl_pkg;

  // register file address width, 32 registers
  localparam int unsigned REG_ADDR_W = 5;

  // controller FSM states
  typedef enum logic [3:0] {
    RESET       = 4'd0,
    BOOT_SET    = 4'd1,
    SLEEP       = 4'd2,
    FIRST_FETCH = 4'd3,
    DECODE      = 4'd4,
    FLUSH_EX    = 4'd5,
    FLUSH_WB    = 4'd6
  } ctrl_state_t;

  // PC source picked by the fetch stage on pc_set
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_t;

  // kind of control transfer sitting in decode
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_kind_t;

  // operand source in ID: register file or a bypass
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_t;

endpackage

// ==== list.f ====
ctrl_pkg.sv
ctrl_fsm.sv
operand_hazard_unit.sv
core_controller.sv
controller_props.sv
tb_core_controller.sv

// ==== operand_hazard_unit.sv ====
//////////////////////////////////////////////////
// operand hazard logic for the ID stage
// address compare against EX and WB, bypass
// selects, load-use and jump-register stalls,
// write enable kill
//////////////////////////////////////////////////

module operand_hazard_unit import ctrl_pkg::*;
(
  input  logic                  is_decoding_i,
  input  logic                  illegal_insn_i,
  input  jump_kind_t            jump_in_dec_i,

  input  logic [REG_ADDR_W-1:0] rs_a_addr_i,
  input  logic [REG_ADDR_W-1:0] rs_b_addr_i,
  input  logic [REG_ADDR_W-1:0] waddr_ex_i,
  input  logic [REG_ADDR_W-1:0] waddr_wb_i,

  input  logic                  rega_used_i,
  input  logic                  regb_used_i,
  input  logic                  we_ex_i,
  input  logic                  alu_we_ex_i,
  input  logic                  we_wb_i,
  input  logic                  data_req_ex_i,

  output fw_sel_t               operand_a_fw_sel_o,
  output fw_sel_t               operand_b_fw_sel_o,
  output logic                  load_stall_o,
  output logic                  jr_stall_o,
  output logic                  deassert_we_o
);

  // source operand hits a pending destination
  logic a_ex_match;
  logic a_wb_match;
  logic b_ex_match;
  logic b_wb_match;

  assign a_ex_match = rega_used_i && (rs_a_addr_i == waddr_ex_i);
  assign a_wb_match = rega_used_i && (rs_a_addr_i == waddr_wb_i);
  assign b_ex_match = regb_used_i && (rs_b_addr_i == waddr_ex_i);
  assign b_wb_match = regb_used_i && (rs_b_addr_i == waddr_wb_i);

  // youngest producer wins, EX before WB
  function automatic fw_sel_t fw_select(input logic ex_hit, input logic wb_hit);
    fw_sel_t sel;
    if (alu_we_ex_i && ex_hit)
      sel = SEL_FW_EX;
    else if (we_wb_i && wb_hit)
      sel = SEL_FW_WB;
    else
      sel = SEL_REGFILE;
    return sel;
  endfunction

  assign operand_a_fw_sel_o = fw_select(a_ex_match, a_wb_match);
  assign operand_b_fw_sel_o = fw_select(b_ex_match, b_wb_match);

  // load data arrives only in WB, so a consumer in ID must wait
  assign load_stall_o = data_req_ex_i && we_ex_i && (a_ex_match || b_ex_match);

  // jalr target is computed in ID from rs1 without a bypass
  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) &&
                      ((we_wb_i && a_wb_match) ||
                       ((we_ex_i || alu_we_ex_i) && a_ex_match));

  // no register write for stalled, illegal or undecoded instructions
  assign deassert_we_o = !is_decoding_i || illegal_insn_i || load_stall_o || jr_stall_o;

endmodule

// ==== tb_core_controller.sv ====
//////////////////////////////////////////////////
// directed testbench for the core controller
// clock, reset, cycle timeout and check helpers
// one task per behavior for boot, hazards, jumps,
// exceptions, flush and sleep
//////////////////////////////////////////////////

module tb_core_controller import ctrl_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  // the tests run for roughly 250 cycles
  localparam int MAX_CYCLES = 1500;

  logic clk;
  logic rst_n;
  logic fetch_enable_i, instr_valid_i, pipe_flush_i, eret_insn_i, illegal_insn_i;
  jump_kind_t jump_in_dec_i;
  logic branch_taken_ex_i, exc_req_i, ext_req_i, id_ready_i, ex_valid_i;
  logic [REG_ADDR_W-1:0] rs_a_addr_i, rs_b_addr_i, waddr_ex_i, waddr_wb_i;
  logic rega_used_i, regb_used_i, we_ex_i, alu_we_ex_i, we_wb_i, data_req_ex_i;
  logic instr_req_o, ctrl_busy_o, is_decoding_o, pc_set_o;
  pc_mux_t pc_mux_o;
  logic exc_ack_o, exc_save_if_o, exc_save_id_o, exc_save_takenbranch_o, exc_restore_id_o;
  logic halt_if_o, halt_id_o;
  fw_sel_t operand_a_fw_sel_o, operand_b_fw_sel_o;
  logic load_stall_o, jr_stall_o, deassert_we_o;

  integer seed;
  int cycle_count = 0;

  core_controller i_core_controller (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////
  // drive and check helpers
  //////////////////////////////////////////////////

  task automatic to_falling_edge();
    @(negedge clk);
  endtask

  // outputs are stable 1 ns before the rising edge
  task automatic settle_before_edge();
    #9;
  endtask

  // fetch_enable_i and id_ready_i keep their values
  task automatic quiet_inputs();
    instr_valid_i = 1'b0;
    pipe_flush_i = 1'b0;
    eret_insn_i = 1'b0;
    illegal_insn_i = 1'b0;
    jump_in_dec_i = BRANCH_NONE;
    branch_taken_ex_i = 1'b0;
    exc_req_i = 1'b0;
    ext_req_i = 1'b0;
    ex_valid_i = 1'b0;
    rs_a_addr_i = '0;
    rs_b_addr_i = '0;
    waddr_ex_i = '0;
    waddr_wb_i = '0;
    rega_used_i = 1'b0;
    regb_used_i = 1'b0;
    we_ex_i = 1'b0;
    alu_we_ex_i = 1'b0;
    we_wb_i = 1'b0;
    data_req_ex_i = 1'b0;
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp)
    else
    begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_code(input string name, input logic [2:0] got, input logic [2:0] exp);
    assert (got === exp)
    else
    begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // mux only matters while pc_set is high
  task automatic check_redirect(input logic set, input pc_mux_t mux);
    check_bit("pc_set_o", pc_set_o, set);
    if (set)
      check_code("pc_mux_o", pc_mux_o, mux);
  endtask

  task automatic check_exception(input logic ack, input logic save_if, input logic save_id,
                                 input logic save_tb, input logic restore);
    check_bit("exc_ack_o", exc_ack_o, ack);
    check_bit("exc_save_if_o", exc_save_if_o, save_if);
    check_bit("exc_save_id_o", exc_save_id_o, save_id);
    check_bit("exc_save_takenbranch_o", exc_save_takenbranch_o, save_tb);
    check_bit("exc_restore_id_o", exc_restore_id_o, restore);
  endtask

  task automatic check_halts(input logic hif, input logic hid);
    check_bit("halt_if_o", halt_if_o, hif);
    check_bit("halt_id_o", halt_id_o, hid);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic reset_and_boot();
    repeat (8) @(posedge clk);
    to_falling_edge();
    rst_n = 1'b1;
    settle_before_edge();
    check_bit("instr_req_o", instr_req_o, 1'b0);
    check_bit("ctrl_busy_o", ctrl_busy_o, 1'b0);
    check_redirect(1'b0, PC_BOOT);
    check_exception(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    check_halts(1'b0, 1'b0);
    check_bit("deassert_we_o", deassert_we_o, 1'b1);
    // fetch enable seen in RESET gives the boot PC one cycle later
    to_falling_edge();
    fetch_enable_i = 1'b1;
    settle_before_edge();
    check_bit("ctrl_busy_o", ctrl_busy_o, 1'b0);
    to_falling_edge();
    id_ready_i = 1'b1;
    settle_before_edge();
    check_redirect(1'b1, PC_BOOT);
    check_bit("ctrl_busy_o", ctrl_busy_o, 1'b1);
    // first fetch with nothing decoded yet
    to_falling_edge();
    instr_valid_i = 1'b1;
    settle_before_edge();
    check_redirect(1'b0, PC_BOOT);
    check_bit("is_decoding_o", is_decoding_o, 1'b0);
    to_falling_edge();
    settle_before_edge();
    check_bit("is_decoding_o", is_decoding_o, 1'b1);
    check_bit("deassert_we_o", deassert_we_o, 1'b0);
  endtask

  task automatic hazards_random();
    logic [31:0] rnd;
    logic [31:0] rnd_hi;
    logic a_ex, a_wb, b_ex, b_wb;
    fw_sel_t exp_a, exp_b;
    logic exp_load, exp_jr;
    for (int n = 0; n < 200; n++)
    begin
      to_falling_edge();
      rnd = $random(seed);
      rnd_hi = $random(seed);
      instr_valid_i = rnd[0];
      illegal_insn_i = (rnd[3:1] == 3'd0);
      jump_in_dec_i = jump_kind_t'(rnd[5:4]);
      // mostly low addresses so matches are frequent
      // upper bits now and then differ to exercise the full compare
      rs_a_addr_i = {((rnd_hi[1:0] == 2'd0) ? rnd_hi[4:2] : 3'b000), rnd[7:6]};
      rs_b_addr_i = {((rnd_hi[6:5] == 2'd0) ? rnd_hi[9:7] : 3'b000), rnd[9:8]};
      waddr_ex_i = {((rnd_hi[11:10] == 2'd0) ? rnd_hi[14:12] : 3'b000), rnd[11:10]};
      waddr_wb_i = {((rnd_hi[16:15] == 2'd0) ? rnd_hi[19:17] : 3'b000), rnd[13:12]};
      rega_used_i = rnd[14];
      regb_used_i = rnd[15];
      we_ex_i = rnd[16];
      alu_we_ex_i = rnd[17];
      we_wb_i = rnd[18];
      data_req_ex_i = rnd[19];
      // expected values from the hazard rules
      a_ex = rega_used_i && (rs_a_addr_i == waddr_ex_i);
      a_wb = rega_used_i && (rs_a_addr_i == waddr_wb_i);
      b_ex = regb_used_i && (rs_b_addr_i == waddr_ex_i);
      b_wb = regb_used_i && (rs_b_addr_i == waddr_wb_i);
      exp_a = (alu_we_ex_i && a_ex) ? SEL_FW_EX : ((we_wb_i && a_wb) ? SEL_FW_WB : SEL_REGFILE);
      exp_b = (alu_we_ex_i && b_ex) ? SEL_FW_EX : ((we_wb_i && b_wb) ? SEL_FW_WB : SEL_REGFILE);
      exp_load = data_req_ex_i && we_ex_i && (a_ex || b_ex);
      exp_jr = (jump_in_dec_i == BRANCH_JALR) &&
               ((we_wb_i && a_wb) || ((we_ex_i || alu_we_ex_i) && a_ex));
      settle_before_edge();
      check_code("operand_a_fw_sel_o", {1'b0, operand_a_fw_sel_o}, {1'b0, exp_a});
      check_code("operand_b_fw_sel_o", {1'b0, operand_b_fw_sel_o}, {1'b0, exp_b});
      check_bit("load_stall_o", load_stall_o, exp_load);
      check_bit("jr_stall_o", jr_stall_o, exp_jr);
      check_bit("is_decoding_o", is_decoding_o, instr_valid_i);
      check_bit("deassert_we_o", deassert_we_o,
                !instr_valid_i || illegal_insn_i || exp_load || exp_jr);
    end
  endtask

  task automatic jumps_and_branches();
    to_falling_edge();
    quiet_inputs();
    instr_valid_i = 1'b1;
    jump_in_dec_i = BRANCH_JAL;
    settle_before_edge();
    check_redirect(1'b1, PC_JUMP);
    // jal held in ID redirects in its first cycle only
    to_falling_edge();
    id_ready_i = 1'b0;
    settle_before_edge();
    check_redirect(1'b1, PC_JUMP);
    to_falling_edge();
    settle_before_edge();
    check_redirect(1'b0, PC_JUMP);
    to_falling_edge();
    id_ready_i = 1'b1;
    settle_before_edge();
    check_redirect(1'b0, PC_JUMP);
    // jalr whose rs1 is still being written in EX
    to_falling_edge();
    quiet_inputs();
    instr_valid_i = 1'b1;
    jump_in_dec_i = BRANCH_JALR;
    rega_used_i = 1'b1;
    rs_a_addr_i = 5'd7;
    waddr_ex_i = 5'd7;
    we_ex_i = 1'b1;
    settle_before_edge();
    check_bit("jr_stall_o", jr_stall_o, 1'b1);
    check_redirect(1'b0, PC_JUMP);
    check_bit("deassert_we_o", deassert_we_o, 1'b1);
    to_falling_edge();
    quiet_inputs();
    instr_valid_i = 1'b1;
    branch_taken_ex_i = 1'b1;
    settle_before_edge();
    check_redirect(1'b1, PC_BRANCH);
    check_bit("is_decoding_o", is_decoding_o, 1'b0);
    to_falling_edge();
    branch_taken_ex_i = 1'b0;
    settle_before_edge();
    check_redirect(1'b0, PC_BRANCH);
    // interrupt on a taken branch returns to the target
    to_falling_edge();
    branch_taken_ex_i = 1'b1;
    ext_req_i = 1'b1;
    settle_before_edge();
    check_redirect(1'b1, PC_EXCEPTION);
    check_exception(1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
    check_bit("halt_id_o", halt_id_o, 1'b1);
  endtask

  task automatic exceptions();
    to_falling_edge();
    quiet_inputs();
    instr_valid_i = 1'b1;
    exc_req_i = 1'b1;
    settle_before_edge();
    check_redirect(1'b1, PC_EXCEPTION);
    check_exception(1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
    check_halts(1'b0, 1'b1);
    // interrupt with an empty ID stage
    to_falling_edge();
    quiet_inputs();
    ext_req_i = 1'b1;
    settle_before_edge();
    check_redirect(1'b1, PC_EXCEPTION);
    check_exception(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
    check_bit("halt_id_o", halt_id_o, 1'b1);
    // eret with fetch enabled and no flush
    to_falling_edge();
    quiet_inputs();
    instr_valid_i = 1'b1;
    eret_insn_i = 1'b1;
    settle_before_edge();
    check_redirect(1'b1, PC_ERET);
    check_exception(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    check_halts(1'b0, 1'b0);
  endtask

  // WFI drain where resume picks the FLUSH_WB exit
  task automatic flush_pipeline(input logic resume);
    to_falling_edge();
    quiet_inputs();
    instr_valid_i = 1'b1;
    pipe_flush_i = 1'b1;
    settle_before_edge();
    check_halts(1'b1, 1'b1);
    repeat (3)
    begin
      to_falling_edge();
      quiet_inputs();
      settle_before_edge();
      check_halts(1'b1, 1'b1);
    end
    to_falling_edge();
    ex_valid_i = 1'b1;
    settle_before_edge();
    check_halts(1'b1, 1'b1);
    to_falling_edge();
    quiet_inputs();
    fetch_enable_i = resume;
    settle_before_edge();
    check_halts(~resume, 1'b1);
  endtask

  task automatic flush_and_sleep();
    flush_pipeline(1'b1);
    to_falling_edge();
    instr_valid_i = 1'b1;
    settle_before_edge();
    check_bit("is_decoding_o", is_decoding_o, 1'b1);
    check_halts(1'b0, 1'b0);
    flush_pipeline(1'b0);
    repeat (2)
    begin
      to_falling_edge();
      settle_before_edge();
      check_bit("ctrl_busy_o", ctrl_busy_o, 1'b0);
      check_bit("instr_req_o", instr_req_o, 1'b0);
      check_halts(1'b1, 1'b1);
    end
    // exception wakes the core and is taken in FIRST_FETCH
    to_falling_edge();
    exc_req_i = 1'b1;
    settle_before_edge();
    check_bit("ctrl_busy_o", ctrl_busy_o, 1'b0);
    to_falling_edge();
    settle_before_edge();
    check_redirect(1'b1, PC_EXCEPTION);
    check_exception(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
    check_bit("ctrl_busy_o", ctrl_busy_o, 1'b1);
    to_falling_edge();
    quiet_inputs();
    fetch_enable_i = 1'b1;
    instr_valid_i = 1'b1;
    settle_before_edge();
    check_bit("is_decoding_o", is_decoding_o, 1'b1);
  endtask

  initial
  begin
    seed = 22146;
    rst_n = 1'b0;
    fetch_enable_i = 1'b0;
    id_ready_i = 1'b0;
    quiet_inputs();
    reset_and_boot();
    hazards_random();
    jumps_and_branches();
    exceptions();
    flush_and_sleep();
    $display("TEST PASSED");
    $finish;
  end

endmodule
